// ==== common/videoCsr_cfg.svh ====
`ifndef VIDEO_CSR_CFG_SVH
`define VIDEO_CSR_CFG_SVH

// ------------------------------
// Bus and block address map
// ------------------------------
`define BUS_DATA_W	32
`define BUS_ADRS_W	24
`define CSR_ADRS_W	16	// Offset field, block field sits above
`define BLOCK_ADRS	8'h04

// ------------------------------
// Field widths
// ------------------------------
`define H_DISP_W	11
`define V_DISP_W	11
`define PORCH_H_W	7	// Also used for the H pulse
`define PORCH_V_W	5	// Also used for the V pulse
`define MEM_ADRS_W	19
`define COLOR_W		16

// ------------------------------
// Reset defaults, 480x272 panel
// ------------------------------
`define H_DISP_DEF	480
`define H_FRONT_DEF	8
`define H_BACK_DEF	43
`define H_PULSE_DEF	30
`define V_DISP_DEF	272
`define V_FRONT_DEF	12
`define V_BACK_DEF	4
`define V_PULSE_DEF	10

// Map in 16 pixel tiles
`define MAP_X_DEF	30
`define MAP_Y_DEF	17

`endif

// ==== common/videoCsrPkg.sv ====
`include "videoCsr_cfg.svh"

package videoCsrPkg;

	// Bus write port, address also serves reads
	typedef struct packed {
		logic [`BUS_DATA_W-1:0]	data;
		logic [`BUS_ADRS_W-1:0]	adrs;
		logic					wrEn;
	} busWriteT;

	// Register offsets inside the block
	typedef enum logic [`CSR_ADRS_W-1:0] {
		RST			= 16'h0000,
		DISP		= 16'h0010,
		BACK		= 16'h0014,
		FRONT		= 16'h0018,
		PULSE		= 16'h001c,
		SYNCSTART	= 16'h0020,	// Read only from here to SYNCMAX
		SYNCEND		= 16'h0024,
		SYNCMAX		= 16'h0028,
		DMAEN		= 16'h0100,
		BLDUTY		= 16'h0104,
		FBADRS1		= 16'h0108,
		FBADRS2		= 16'h010c,
		FBLEN1		= 16'h0110,
		FBLEN2		= 16'h0114,
		MAPSIZE		= 16'h0200,
		SCNCOLOR	= 16'h0300,
		SCNTIMING	= 16'h0304,
		SCNCTRL		= 16'h0308,
		SCNALPHA	= 16'h030c	// Status, read only
	} csrOffsetE;

	// One write strobe per writable register
	typedef struct packed {
		logic rst;
		logic disp;
		logic back;
		logic front;
		logic pulse;
		logic dmaEn;
		logic blDuty;
		logic fbAdrs1;
		logic fbAdrs2;
		logic fbLen1;
		logic fbLen2;
		logic mapSize;
		logic scnColor;
		logic scnTiming;
		logic scnCtrl;
	} csrSelT;

	typedef struct packed {
		logic [`H_DISP_W-1:0]	hDisp;
		logic [`V_DISP_W-1:0]	vDisp;
		logic [`PORCH_H_W-1:0]	hFront;
		logic [`PORCH_H_W-1:0]	hBack;
		logic [`PORCH_H_W-1:0]	hPulse;
		logic [`PORCH_V_W-1:0]	vFront;
		logic [`PORCH_V_W-1:0]	vBack;
		logic [`PORCH_V_W-1:0]	vPulse;
	} displayTimingT;

	// One bit of headroom over the display width
	typedef struct packed {
		logic [`H_DISP_W:0]	hStart;
		logic [`H_DISP_W:0]	hEnd;
		logic [`H_DISP_W:0]	hMax;
		logic [`V_DISP_W:0]	vStart;
		logic [`V_DISP_W:0]	vEnd;
		logic [`V_DISP_W:0]	vMax;
	} syncPointsT;

	// Packed in register bit order, sys is bit 0
	typedef struct packed {
		logic disp;		// Active low
		logic video;
		logic sys;
	} videoRstT;

	typedef struct packed {
		logic					en;
		logic [`MEM_ADRS_W-1:0]	fbAdrs1;	// Write DMA start
		logic [`MEM_ADRS_W-1:0]	fbAdrs2;	// Read DMA start
		logic [`MEM_ADRS_W-1:0]	fbLen1;
		logic [`MEM_ADRS_W-1:0]	fbLen2;
	} dmaCfgT;

	typedef struct packed {
		logic [7:0] x;
		logic [7:0] y;
	} mapSizeT;

	typedef struct packed {
		logic [`COLOR_W-1:0]	color;
		logic [6:0]				frameTiming;	// Update rate in frames
		logic					rst;
		logic					subEn;
		logic					addEn;
	} sceneCfgT;

	typedef struct packed {
		logic alphaMax;
		logic alphaMin;
	} sceneStatusT;

endpackage

// ==== videoCsr/csrWriteDecode.sv ====
`include "videoCsr_cfg.svh"

module csrWriteDecode (
	input	videoCsrPkg::busWriteT	busWrite,
	output	videoCsrPkg::csrSelT	csrSel,
	output	logic					blockHit
);
	import videoCsrPkg::*;

	localparam int BLOCK_W = `BUS_ADRS_W - `CSR_ADRS_W;

	logic [BLOCK_W-1:0]		blockField;
	logic [`CSR_ADRS_W-1:0]	offset;
	logic					wrHit;

	assign blockField	= busWrite.adrs[`BUS_ADRS_W-1:`CSR_ADRS_W];
	assign offset		= busWrite.adrs[`CSR_ADRS_W-1:0];
	assign blockHit		= (blockField == `BLOCK_ADRS);	// Reads use it too
	assign wrHit		= blockHit & busWrite.wrEn;

	always_comb
	begin
		csrSel.rst			= wrHit & (offset == RST);
		// Display timing
		csrSel.disp			= wrHit & (offset == DISP);
		csrSel.back			= wrHit & (offset == BACK);
		csrSel.front		= wrHit & (offset == FRONT);
		csrSel.pulse		= wrHit & (offset == PULSE);
		// DMA and panel
		csrSel.dmaEn		= wrHit & (offset == DMAEN);
		csrSel.blDuty		= wrHit & (offset == BLDUTY);
		csrSel.fbAdrs1		= wrHit & (offset == FBADRS1);
		csrSel.fbAdrs2		= wrHit & (offset == FBADRS2);
		csrSel.fbLen1		= wrHit & (offset == FBLEN1);
		csrSel.fbLen2		= wrHit & (offset == FBLEN2);
		csrSel.mapSize		= wrHit & (offset == MAPSIZE);
		// Scene change
		csrSel.scnColor		= wrHit & (offset == SCNCOLOR);
		csrSel.scnTiming	= wrHit & (offset == SCNTIMING);
		csrSel.scnCtrl		= wrHit & (offset == SCNCTRL);
	end

endmodule

// ==== videoCsr/displayTimingRegs.sv ====
`include "videoCsr_cfg.svh"

module displayTimingRegs (
	input	logic						iSysClk,
	input	logic						rstN,
	input	videoCsrPkg::csrSelT		csrSel,
	input	logic [`BUS_DATA_W-1:0]		wrData,
	output	videoCsrPkg::displayTimingT	timing,
	output	videoCsrPkg::syncPointsT	syncPoints
);

	localparam int HALF_W	= `BUS_DATA_W / 2;	// V in upper half, H in lower
	localparam int HSYNC_W	= `H_DISP_W + 1;
	localparam int VSYNC_W	= `V_DISP_W + 1;

	// Sync points of the default panel
	localparam logic [HSYNC_W-1:0] H_START_DEF = HSYNC_W'(`H_DISP_DEF + `H_FRONT_DEF);
	localparam logic [HSYNC_W-1:0] H_END_DEF = HSYNC_W'(H_START_DEF + `H_PULSE_DEF - 1);
	localparam logic [HSYNC_W-1:0] H_MAX_DEF = HSYNC_W'(H_END_DEF + `H_BACK_DEF);
	localparam logic [VSYNC_W-1:0] V_START_DEF = VSYNC_W'(`V_DISP_DEF + `V_FRONT_DEF);
	localparam logic [VSYNC_W-1:0] V_END_DEF = VSYNC_W'(V_START_DEF + `V_PULSE_DEF - 1);
	localparam logic [VSYNC_W-1:0] V_MAX_DEF = VSYNC_W'(V_END_DEF + `V_BACK_DEF);

	logic [HSYNC_W-1:0] hStartNext, hEndNext, hMaxNext;
	logic [VSYNC_W-1:0] vStartNext, vEndNext, vMaxNext;

	// ------------------------------
	// Timing registers
	// ------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			timing.hDisp	<= `H_DISP_W'(`H_DISP_DEF);
			timing.vDisp	<= `V_DISP_W'(`V_DISP_DEF);
			timing.hFront	<= `PORCH_H_W'(`H_FRONT_DEF);
			timing.hBack	<= `PORCH_H_W'(`H_BACK_DEF);
			timing.hPulse	<= `PORCH_H_W'(`H_PULSE_DEF);
			timing.vFront	<= `PORCH_V_W'(`V_FRONT_DEF);
			timing.vBack	<= `PORCH_V_W'(`V_BACK_DEF);
			timing.vPulse	<= `PORCH_V_W'(`V_PULSE_DEF);
		end
		else
		begin
			if (csrSel.disp)
			begin
				timing.vDisp <= wrData[HALF_W +: `V_DISP_W];
				timing.hDisp <= wrData[0 +: `H_DISP_W];
			end
			if (csrSel.back)
			begin
				timing.vBack <= wrData[HALF_W +: `PORCH_V_W];
				timing.hBack <= wrData[0 +: `PORCH_H_W];
			end
			if (csrSel.front)
			begin
				timing.vFront <= wrData[HALF_W +: `PORCH_V_W];
				timing.hFront <= wrData[0 +: `PORCH_H_W];
			end
			if (csrSel.pulse)
			begin
				timing.vPulse <= wrData[HALF_W +: `PORCH_V_W];
				timing.hPulse <= wrData[0 +: `PORCH_H_W];
			end
		end
	end

	// Sync points, chained sums
	assign hStartNext	= HSYNC_W'(timing.hDisp) + HSYNC_W'(timing.hFront);
	assign hEndNext		= hStartNext + HSYNC_W'(timing.hPulse) - HSYNC_W'(1);
	assign hMaxNext		= hEndNext + HSYNC_W'(timing.hBack);
	assign vStartNext	= VSYNC_W'(timing.vDisp) + VSYNC_W'(timing.vFront);
	assign vEndNext		= vStartNext + VSYNC_W'(timing.vPulse) - VSYNC_W'(1);
	assign vMaxNext		= vEndNext + VSYNC_W'(timing.vBack);

	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
			syncPoints <= {H_START_DEF, H_END_DEF, H_MAX_DEF, V_START_DEF, V_END_DEF, V_MAX_DEF};
		else
			syncPoints <= {hStartNext, hEndNext, hMaxNext, vStartNext, vEndNext, vMaxNext};
	end

	// Sync points trail the timing registers by one edge
	property pSyncOrder;
		@(posedge iSysClk) disable iff (!rstN)
		(timing.hPulse != '0 && timing.vPulse != '0) |=>
			(syncPoints.hMax >= syncPoints.hEnd && syncPoints.vMax >= syncPoints.vEnd);
	endproperty
	aSyncOrder: assert property (pSyncOrder)
		else $error("displayTimingRegs: sync max below sync end");

endmodule

// ==== videoCsr/videoCtrlRegs.sv ====
`include "videoCsr_cfg.svh"

module videoCtrlRegs (
	input	logic					iSysClk,
	input	logic					rstN,
	input	videoCsrPkg::csrSelT	csrSel,
	input	logic [`BUS_DATA_W-1:0]	wrData,
	output	videoCsrPkg::videoRstT	videoRst,
	output	videoCsrPkg::dmaCfgT	dmaCfg,
	output	logic [7:0]				blDutyRatio,
	output	videoCsrPkg::mapSizeT	mapSize
);

	// One frame of the default panel
	localparam logic [`MEM_ADRS_W-1:0] FB_SIZE =
		`MEM_ADRS_W'(`H_DISP_DEF * `V_DISP_DEF);
	localparam logic [`MEM_ADRS_W-1:0] FB_SIZE2 =
		`MEM_ADRS_W'(2 * `H_DISP_DEF * `V_DISP_DEF);

	// ------------------------------
	// Reset bits
	// ------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
			videoRst <= 3'b111;	// Display reset is active low, so it runs
		else if (csrSel.rst)
			videoRst <= wrData[2:0];
	end

	// ------------------------------
	// DMA and backlight
	// ------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			dmaCfg.en		<= 1'b0;
			dmaCfg.fbAdrs1	<= '0;
			dmaCfg.fbAdrs2	<= FB_SIZE;		// Second buffer right after the first
			dmaCfg.fbLen1	<= FB_SIZE;
			dmaCfg.fbLen2	<= FB_SIZE2;
			blDutyRatio		<= 8'h00;		// Backlight off
		end
		else
		begin
			if (csrSel.dmaEn)
				dmaCfg.en <= wrData[0];
			if (csrSel.fbAdrs1)
				dmaCfg.fbAdrs1 <= wrData[`MEM_ADRS_W-1:0];
			if (csrSel.fbAdrs2)
				dmaCfg.fbAdrs2 <= wrData[`MEM_ADRS_W-1:0];
			if (csrSel.fbLen1)
				dmaCfg.fbLen1 <= wrData[`MEM_ADRS_W-1:0];
			if (csrSel.fbLen2)
				dmaCfg.fbLen2 <= wrData[`MEM_ADRS_W-1:0];
			if (csrSel.blDuty)
				blDutyRatio <= wrData[7:0];
		end
	end

	// Map size in tiles, x over y
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			mapSize.x <= 8'(`MAP_X_DEF);
			mapSize.y <= 8'(`MAP_Y_DEF);
		end
		else if (csrSel.mapSize)
			mapSize <= wrData[15:0];
	end

endmodule

// ==== videoCsr/sceneCtrlRegs.sv ====
`include "videoCsr_cfg.svh"

module sceneCtrlRegs (
	input	logic						iSysClk,
	input	logic						rstN,
	input	videoCsrPkg::csrSelT		csrSel,
	input	logic [`BUS_DATA_W-1:0]		wrData,
	input	videoCsrPkg::sceneStatusT	sceneStatusIn,
	output	videoCsrPkg::sceneCfgT		sceneCfg,
	output	videoCsrPkg::sceneStatusT	sceneStatus
);

	// ------------------------------
	// Scene change control
	// ------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			sceneCfg.color			<= '0;
			sceneCfg.frameTiming	<= '0;
			sceneCfg.addEn			<= 1'b0;
			sceneCfg.subEn			<= 1'b0;
			sceneCfg.rst			<= 1'b1;	// Fader held in reset
		end
		else
		begin
			if (csrSel.scnColor)
				sceneCfg.color <= wrData[`COLOR_W-1:0];
			if (csrSel.scnTiming)
				sceneCfg.frameTiming <= wrData[6:0];
			if (csrSel.scnCtrl)
			begin
				sceneCfg.addEn	<= wrData[0];	// Fade in
				sceneCfg.subEn	<= wrData[1];	// Fade out
				sceneCfg.rst	<= wrData[2];
			end
		end
	end

	// Alpha limits from the fader, sampled every cycle
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
			sceneStatus <= '0;
		else
			sceneStatus <= sceneStatusIn;
	end

endmodule

// ==== videoCsr/csrReadback.sv ====
`include "videoCsr_cfg.svh"

module csrReadback (
	input	logic						iSysClk,
	input	logic						rstN,
	input	logic [`BUS_ADRS_W-1:0]		rdAdrs,
	input	logic						blockHit,
	input	videoCsrPkg::displayTimingT	timing,
	input	videoCsrPkg::syncPointsT	syncPoints,
	input	videoCsrPkg::videoRstT		videoRst,
	input	videoCsrPkg::dmaCfgT		dmaCfg,
	input	logic [7:0]					blDutyRatio,
	input	videoCsrPkg::mapSizeT		mapSize,
	input	videoCsrPkg::sceneCfgT		sceneCfg,
	input	videoCsrPkg::sceneStatusT	sceneStatus,
	output	logic [`BUS_DATA_W-1:0]		rd,
	output	logic						rdValid
);
	import videoCsrPkg::*;

	localparam int DATA_W = `BUS_DATA_W;
	localparam int HALF_W = DATA_W / 2;

	logic [`CSR_ADRS_W-1:0]	offset;
	logic [DATA_W-1:0]		rdNext;

	// Same V/H split as the write side
	function automatic logic [DATA_W-1:0] packVH(
		input logic [HALF_W-1:0] v,
		input logic [HALF_W-1:0] h
	);
		return {v, h};
	endfunction

	assign offset = rdAdrs[`CSR_ADRS_W-1:0];

	// ------------------------------
	// Register image by offset
	// ------------------------------
	always_comb
	begin
		case (offset)
			RST:		rdNext = DATA_W'(videoRst);
			DISP:		rdNext = packVH(HALF_W'(timing.vDisp), HALF_W'(timing.hDisp));
			BACK:		rdNext = packVH(HALF_W'(timing.vBack), HALF_W'(timing.hBack));
			FRONT:		rdNext = packVH(HALF_W'(timing.vFront), HALF_W'(timing.hFront));
			PULSE:		rdNext = packVH(HALF_W'(timing.vPulse), HALF_W'(timing.hPulse));
			SYNCSTART:	rdNext = packVH(HALF_W'(syncPoints.vStart), HALF_W'(syncPoints.hStart));
			SYNCEND:	rdNext = packVH(HALF_W'(syncPoints.vEnd), HALF_W'(syncPoints.hEnd));
			SYNCMAX:	rdNext = packVH(HALF_W'(syncPoints.vMax), HALF_W'(syncPoints.hMax));
			DMAEN:		rdNext = DATA_W'(dmaCfg.en);
			BLDUTY:		rdNext = DATA_W'(blDutyRatio);
			FBADRS1:	rdNext = DATA_W'(dmaCfg.fbAdrs1);
			FBADRS2:	rdNext = DATA_W'(dmaCfg.fbAdrs2);
			FBLEN1:		rdNext = DATA_W'(dmaCfg.fbLen1);
			FBLEN2:		rdNext = DATA_W'(dmaCfg.fbLen2);
			MAPSIZE:	rdNext = DATA_W'(mapSize);
			SCNCOLOR:	rdNext = DATA_W'(sceneCfg.color);
			SCNTIMING:	rdNext = DATA_W'(sceneCfg.frameTiming);
			SCNCTRL:	rdNext = DATA_W'({sceneCfg.rst, sceneCfg.subEn, sceneCfg.addEn});
			SCNALPHA:	rdNext = DATA_W'(sceneStatus);
			default:	rdNext = '0;	// Unmapped offset
		endcase
	end

	// Data and valid line up one cycle after the address
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			rd		<= '0;
			rdValid	<= 1'b0;
		end
		else
		begin
			rd		<= rdNext;
			rdValid	<= blockHit;
		end
	end

endmodule

// ==== verilog/videoCsr.sv ====
`include "videoCsr_cfg.svh"

module videoCsr (
	input	logic						iSysClk,
	input	logic						rstN,
	input	videoCsrPkg::busWriteT		busWrite,
	input	videoCsrPkg::sceneStatusT	sceneStatusIn,
	output	logic [`BUS_DATA_W-1:0]		rd,
	output	logic						rdValid,
	output	videoCsrPkg::videoRstT		videoRst,
	output	videoCsrPkg::displayTimingT	timing,
	output	videoCsrPkg::syncPointsT	syncPoints,
	output	videoCsrPkg::dmaCfgT		dmaCfg,
	output	logic [7:0]					blDutyRatio,
	output	videoCsrPkg::mapSizeT		mapSize,
	output	videoCsrPkg::sceneCfgT		sceneCfg
);
	import videoCsrPkg::*;

	csrSelT			csrSel;
	logic			blockHit;
	sceneStatusT	sceneStatus;	// Registered alpha flags, read only

	// ------------------------------
	// Write decode
	// ------------------------------
	csrWriteDecode csrWriteDecode_i (
		.busWrite	(busWrite),
		.csrSel		(csrSel),
		.blockHit	(blockHit)
	);

	// ------------------------------
	// Register groups
	// ------------------------------
	displayTimingRegs displayTimingRegs_i (
		.iSysClk	(iSysClk),
		.rstN		(rstN),
		.csrSel		(csrSel),
		.wrData		(busWrite.data),
		.timing		(timing),
		.syncPoints	(syncPoints)
	);

	videoCtrlRegs videoCtrlRegs_i (
		.iSysClk		(iSysClk),
		.rstN			(rstN),
		.csrSel			(csrSel),
		.wrData			(busWrite.data),
		.videoRst		(videoRst),
		.dmaCfg			(dmaCfg),
		.blDutyRatio	(blDutyRatio),
		.mapSize		(mapSize)
	);

	sceneCtrlRegs sceneCtrlRegs_i (
		.iSysClk		(iSysClk),
		.rstN			(rstN),
		.csrSel			(csrSel),
		.wrData			(busWrite.data),
		.sceneStatusIn	(sceneStatusIn),
		.sceneCfg		(sceneCfg),
		.sceneStatus	(sceneStatus)
	);

	// Bus address doubles as the read address
	csrReadback csrReadback_i (
		.iSysClk		(iSysClk),
		.rstN			(rstN),
		.rdAdrs			(busWrite.adrs),
		.blockHit		(blockHit),
		.timing			(timing),
		.syncPoints		(syncPoints),
		.videoRst		(videoRst),
		.dmaCfg			(dmaCfg),
		.blDutyRatio	(blDutyRatio),
		.mapSize		(mapSize),
		.sceneCfg		(sceneCfg),
		.sceneStatus	(sceneStatus),
		.rd				(rd),
		.rdValid		(rdValid)
	);

endmodule

// ==== test/tbClockGen.sv ====
module tbClockGen #(
	parameter int PERIOD = 40
) (
	output logic iSysClk
);

	// Free running, starts low
	initial
	begin
		iSysClk = 1'b0;
		forever
		begin
			#(PERIOD / 2) iSysClk = ~iSysClk;
		end
	end

endmodule

// ==== test/videoCsrTb.sv ====
`include "videoCsr_cfg.svh"

module videoCsrTb;
	import videoCsrPkg::*;

	localparam int RST_CYCLES	= 10;
	localparam int N_MAPPED		= 19;
	localparam int N_WRITES		= 300;
	localparam int N_TIMING		= 40;
	localparam int N_STATUS		= 60;
	localparam int N_BAD		= 40;
	localparam int HS_W			= `H_DISP_W + 1;
	localparam int VS_W			= `V_DISP_W + 1;
	// Write plus readback, eight steps per timing round, two per bad address
	localparam int TEST_CYCLES	= RST_CYCLES + N_MAPPED + 2 * N_WRITES + 8 * N_TIMING
		+ N_STATUS + 2 * N_BAD;
	localparam int CYCLE_LIMIT	= TEST_CYCLES + 900;

	logic					iSysClk;
	logic					rstN;
	busWriteT				busWrite;
	sceneStatusT			sceneStatusIn;
	logic [`BUS_DATA_W-1:0]	rd;
	logic					rdValid;
	videoRstT				videoRst;
	displayTimingT			timing;
	syncPointsT				syncPoints;
	dmaCfgT					dmaCfg;
	logic [7:0]				blDutyRatio;
	mapSizeT				mapSize;
	sceneCfgT				sceneCfg;

	// ------------------------------
	// Register model
	// ------------------------------
	displayTimingT	mTiming;
	syncPointsT		mSync;
	videoRstT		mRst;
	dmaCfgT			mDma;
	logic [7:0]		mDuty;
	mapSizeT		mMap;
	sceneCfgT		mScene;
	sceneStatusT	mStatus;

	logic [31:0]	rngState = 32'h47bb;
	int				cycleCount = 0;

	logic [15:0] wrOffs [15] = '{RST, DISP, BACK, FRONT, PULSE, DMAEN, BLDUTY, FBADRS1,
		FBADRS2, FBLEN1, FBLEN2, MAPSIZE, SCNCOLOR, SCNTIMING, SCNCTRL};
	logic [15:0] rdOffs [N_MAPPED] = '{RST, DISP, BACK, FRONT, PULSE, SYNCSTART, SYNCEND,
		SYNCMAX, DMAEN, BLDUTY, FBADRS1, FBADRS2, FBLEN1, FBLEN2, MAPSIZE, SCNCOLOR,
		SCNTIMING, SCNCTRL, SCNALPHA};

	tbClockGen #(.PERIOD(40)) clkGen_i (
		.iSysClk	(iSysClk)
	);

	videoCsr videoCsr_i (
		.iSysClk		(iSysClk),
		.rstN			(rstN),
		.busWrite		(busWrite),
		.sceneStatusIn	(sceneStatusIn),
		.rd				(rd),
		.rdValid		(rdValid),
		.videoRst		(videoRst),
		.timing			(timing),
		.syncPoints		(syncPoints),
		.dmaCfg			(dmaCfg),
		.blDutyRatio	(blDutyRatio),
		.mapSize		(mapSize),
		.sceneCfg		(sceneCfg)
	);

	// Xorshift32
	function automatic logic [31:0] nextRand();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	// Start, then pulse minus one, then back porch
	function automatic syncPointsT syncFrom(input displayTimingT t);
		syncPointsT s;
		s.hStart	= HS_W'(t.hDisp) + HS_W'(t.hFront);
		s.hEnd		= s.hStart + HS_W'(t.hPulse) - HS_W'(1);
		s.hMax		= s.hEnd + HS_W'(t.hBack);
		s.vStart	= VS_W'(t.vDisp) + VS_W'(t.vFront);
		s.vEnd		= s.vStart + VS_W'(t.vPulse) - VS_W'(1);
		s.vMax		= s.vEnd + VS_W'(t.vBack);
		return s;
	endfunction

	function automatic logic isMapped(input logic [15:0] off);
		logic hit;
		hit = 1'b0;
		foreach (rdOffs[i])
			if (rdOffs[i] == off)
				hit = 1'b1;
		return hit;
	endfunction

	task automatic resetModel();
		mTiming.hDisp	= `H_DISP_W'(`H_DISP_DEF);
		mTiming.vDisp	= `V_DISP_W'(`V_DISP_DEF);
		mTiming.hFront	= `PORCH_H_W'(`H_FRONT_DEF);
		mTiming.hBack	= `PORCH_H_W'(`H_BACK_DEF);
		mTiming.hPulse	= `PORCH_H_W'(`H_PULSE_DEF);
		mTiming.vFront	= `PORCH_V_W'(`V_FRONT_DEF);
		mTiming.vBack	= `PORCH_V_W'(`V_BACK_DEF);
		mTiming.vPulse	= `PORCH_V_W'(`V_PULSE_DEF);
		mSync			= syncFrom(mTiming);
		mRst			= 3'b111;
		mDma.en			= 1'b0;
		mDma.fbAdrs1	= '0;
		mDma.fbAdrs2	= `MEM_ADRS_W'(`H_DISP_DEF * `V_DISP_DEF);
		mDma.fbLen1		= `MEM_ADRS_W'(`H_DISP_DEF * `V_DISP_DEF);
		mDma.fbLen2		= `MEM_ADRS_W'(2 * `H_DISP_DEF * `V_DISP_DEF);
		mDuty			= 8'h00;
		mMap.x			= 8'(`MAP_X_DEF);
		mMap.y			= 8'(`MAP_Y_DEF);
		mScene			= '0;
		mScene.rst		= 1'b1;
		mStatus			= '0;
	endtask

	task automatic applyWrite(input logic [15:0] off, input logic [31:0] d);
		case (off)
			RST:		mRst = d[2:0];
			DISP:		{mTiming.vDisp, mTiming.hDisp} = {d[26:16], d[10:0]};
			BACK:		{mTiming.vBack, mTiming.hBack} = {d[20:16], d[6:0]};
			FRONT:		{mTiming.vFront, mTiming.hFront} = {d[20:16], d[6:0]};
			PULSE:		{mTiming.vPulse, mTiming.hPulse} = {d[20:16], d[6:0]};
			DMAEN:		mDma.en = d[0];
			BLDUTY:		mDuty = d[7:0];
			FBADRS1:	mDma.fbAdrs1 = d[18:0];
			FBADRS2:	mDma.fbAdrs2 = d[18:0];
			FBLEN1:		mDma.fbLen1 = d[18:0];
			FBLEN2:		mDma.fbLen2 = d[18:0];
			MAPSIZE:	{mMap.x, mMap.y} = d[15:0];
			SCNCOLOR:	mScene.color = d[15:0];
			SCNTIMING:	mScene.frameTiming = d[6:0];
			SCNCTRL:	{mScene.rst, mScene.subEn, mScene.addEn} = d[2:0];
			default:	;	// Read only or unmapped
		endcase
	endtask

	// Zero padded register image, V high and H low
	function automatic logic [31:0] readImage(input logic [15:0] off);
		logic [31:0] r;
		case (off)
			RST:		r = {29'd0, mRst.disp, mRst.video, mRst.sys};
			DISP:		r = {5'd0, mTiming.vDisp, 5'd0, mTiming.hDisp};
			BACK:		r = {11'd0, mTiming.vBack, 9'd0, mTiming.hBack};
			FRONT:		r = {11'd0, mTiming.vFront, 9'd0, mTiming.hFront};
			PULSE:		r = {11'd0, mTiming.vPulse, 9'd0, mTiming.hPulse};
			SYNCSTART:	r = {4'd0, mSync.vStart, 4'd0, mSync.hStart};
			SYNCEND:	r = {4'd0, mSync.vEnd, 4'd0, mSync.hEnd};
			SYNCMAX:	r = {4'd0, mSync.vMax, 4'd0, mSync.hMax};
			DMAEN:		r = {31'd0, mDma.en};
			BLDUTY:		r = {24'd0, mDuty};
			FBADRS1:	r = {13'd0, mDma.fbAdrs1};
			FBADRS2:	r = {13'd0, mDma.fbAdrs2};
			FBLEN1:		r = {13'd0, mDma.fbLen1};
			FBLEN2:		r = {13'd0, mDma.fbLen2};
			MAPSIZE:	r = {16'd0, mMap.x, mMap.y};
			SCNCOLOR:	r = {16'd0, mScene.color};
			SCNTIMING:	r = {25'd0, mScene.frameTiming};
			SCNCTRL:	r = {29'd0, mScene.rst, mScene.subEn, mScene.addEn};
			SCNALPHA:	r = {30'd0, mStatus.alphaMax, mStatus.alphaMin};
			default:	r = '0;
		endcase
		return r;
	endfunction

	// ------------------------------
	// Compare tasks
	// ------------------------------
	task automatic reportError(input string msg);
		$display("ERR %0t: %s", $time, msg);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic checkRead(input logic [31:0] expRd, input logic expValid);
		if (rdValid !== expValid)
			reportError($sformatf("rdValid %0b, expected %0b", rdValid, expValid));
		else if (expValid && rd !== expRd)	// rd is don't care when not valid
			reportError($sformatf("rd %h, expected %h", rd, expRd));
	endtask

	task automatic checkTiming(input displayTimingT expT, input syncPointsT expS);
		if (timing !== expT)
			reportError($sformatf("timing %h, expected %h", timing, expT));
		else if (syncPoints !== expS)
			reportError($sformatf("syncPoints %h, expected %h", syncPoints, expS));
	endtask

	task automatic checkVideo(input videoRstT expRst, input dmaCfgT expDma,
		input logic [7:0] expDuty, input mapSizeT expMap);
		if (videoRst !== expRst)
			reportError($sformatf("videoRst %b, expected %b", videoRst, expRst));
		else if (dmaCfg !== expDma)
			reportError($sformatf("dmaCfg %h, expected %h", dmaCfg, expDma));
		else if (blDutyRatio !== expDuty)
			reportError($sformatf("blDutyRatio %h, expected %h", blDutyRatio, expDuty));
		else if (mapSize !== expMap)
			reportError($sformatf("mapSize %h, expected %h", mapSize, expMap));
	endtask

	task automatic checkScene(input sceneCfgT expScene);
		if (sceneCfg !== expScene)
			reportError($sformatf("sceneCfg %h, expected %h", sceneCfg, expScene));
	endtask

	task automatic checkAll();
		checkTiming(mTiming, mSync);
		checkVideo(mRst, mDma, mDuty, mMap);
		checkScene(mScene);
	endtask

	// One bus cycle, driven at the falling edge and checked at the next one
	task automatic busStep(input logic [23:0] adrs, input logic [31:0] data,
		input logic wrEn, input sceneStatusT status);
		logic [31:0]	expRd;
		logic			expValid;
		syncPointsT		nextSync;
		busWrite.adrs	= adrs;
		busWrite.data	= data;
		busWrite.wrEn	= wrEn;
		sceneStatusIn	= status;
		expValid		= (adrs[23:16] == `BLOCK_ADRS);
		expRd			= readImage(adrs[15:0]);	// Contents before this edge
		nextSync		= syncFrom(mTiming);
		if (expValid && wrEn)
			applyWrite(adrs[15:0], data);
		mSync	= nextSync;
		mStatus	= status;
		@(posedge iSysClk);
		@(negedge iSysClk);
		checkRead(expRd, expValid);
		checkAll();
	endtask

	// Timeout guard
	always @(posedge iSysClk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT)
		begin
			$display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$fatal(1, "cycle limit reached");
		end
	end

	// ------------------------------
	// Stimulus
	// ------------------------------
	initial
	begin
		int				idx;
		logic [15:0]	off;
		logic [31:0]	data;
		logic [7:0]		blk;
		logic [1:0]		st;
		rstN			= 1'b0;
		busWrite		= '0;
		sceneStatusIn	= '0;
		resetModel();
		repeat (RST_CYCLES) @(negedge iSysClk);
		rstN = 1'b1;

		// Reset defaults, outputs then every mapped read
		checkRead('0, 1'b0);
		checkAll();
		foreach (rdOffs[i])
			busStep({`BLOCK_ADRS, rdOffs[i]}, 32'd0, 1'b0, 2'b00);

		// Random writes, each one read back
		for (int i = 0; i < N_WRITES; i++)
		begin
			idx		= int'(nextRand() % 32'd15);
			off		= wrOffs[idx];
			data	= nextRand();
			busStep({`BLOCK_ADRS, off}, data, 1'b1, 2'b00);
			busStep({`BLOCK_ADRS, off}, nextRand(), 1'b0, 2'b00);
		end

		// Timing rounds then sync readback
		for (int i = 0; i < N_TIMING; i++)
		begin
			busStep({`BLOCK_ADRS, 16'(DISP)}, nextRand(), 1'b1, 2'b00);
			busStep({`BLOCK_ADRS, 16'(BACK)}, nextRand(), 1'b1, 2'b00);
			busStep({`BLOCK_ADRS, 16'(FRONT)}, nextRand(), 1'b1, 2'b00);
			busStep({`BLOCK_ADRS, 16'(PULSE)}, nextRand(), 1'b1, 2'b00);
			busStep({`BLOCK_ADRS, 16'(DISP)}, 32'd0, 1'b0, 2'b00);
			busStep({`BLOCK_ADRS, 16'(SYNCSTART)}, 32'd0, 1'b0, 2'b00);
			busStep({`BLOCK_ADRS, 16'(SYNCEND)}, 32'd0, 1'b0, 2'b00);
			busStep({`BLOCK_ADRS, 16'(SYNCMAX)}, 32'd0, 1'b0, 2'b00);
		end

		// Alpha flags, read one step behind
		for (int i = 0; i < N_STATUS; i++)
		begin
			st = 2'(nextRand());
			busStep({`BLOCK_ADRS, 16'(SCNALPHA)}, 32'd0, 1'b0, st);
		end

		// Unmapped offsets and foreign blocks
		for (int i = 0; i < N_BAD; i++)
		begin
			off = 16'(nextRand());
			while (isMapped(off))
				off = 16'(nextRand());
			busStep({`BLOCK_ADRS, off}, nextRand(), 1'b1, 2'b00);
			blk = 8'(nextRand());
			if (blk == `BLOCK_ADRS)
				blk = blk ^ 8'h01;
			idx = int'(nextRand() % 32'd15);
			busStep({blk, wrOffs[idx]}, nextRand(), 1'b1, 2'b00);	// Must not write
		end

		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+common
common/videoCsrPkg.sv
videoCsr/csrWriteDecode.sv
videoCsr/displayTimingRegs.sv
videoCsr/videoCtrlRegs.sv
videoCsr/sceneCtrlRegs.sv
videoCsr/csrReadback.sv
verilog/videoCsr.sv
test/tbClockGen.sv
test/videoCsrTb.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the videoCsr testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module videoCsrTb

# The simulation may exit non-zero on failure, so the log decides
./obj_dir/VvideoCsrTb 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
